/* source/matmul_params.svh */
`ifndef MATMUL_PARAMS_SVH
`define MATMUL_PARAMS_SVH

// element and result sizes
`define ELEM_W       2
`define PROD_W       4   // 2 * ELEM_W
`define RESULT_W     5   // sum of two products, max 18
`define WORD_W       8   // memory word and apb data

// operand memory map, in words
`define RAM_WORDS    12
`define RAM_ADDR_W   4
`define A_BASE       0
`define B_BASE       4
`define C_BASE       8

// registers above the memory
`define REG_CTRL     12
`define REG_STATUS   13
`define REG_DISP_SEL 14

// digit scan, short so all four digits show up quickly
`define SCAN_CNT_W   4
`define NUM_DIGITS   4

`endif

/* source/matmul_pkg.sv */
`include "matmul_params.svh"

package matmul_pkg;

    typedef logic [`ELEM_W-1:0]     elem_t;
    typedef logic [`PROD_W-1:0]     prod_t;
    typedef logic [`RESULT_W-1:0]   result_t;
    typedef logic [`RAM_ADDR_W-1:0] ram_addr_t;

    // one memory word, holding either an operand or a result
    typedef union packed {
        struct packed {
            logic [`WORD_W-`ELEM_W-1:0] pad;
            elem_t                      value;
        } operand;                              // words 0 to 7
        struct packed {
            logic [`WORD_W-`RESULT_W-1:0] pad;
            result_t                      value;
        } result;                               // words 8 to 11
    } ram_word_u;

endpackage

/* source/apb_matrix_port.sv */
`include "matmul_params.svh"

module apb_matrix_port (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  matmul_pkg::ram_addr_t paddr,
    input  logic [`WORD_W-1:0]    pwdata,
    output logic [`WORD_W-1:0]    prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  logic                  busy,
    input  logic                  done,
    output logic                  start,
    output logic [1:0]            disp_sel,
    output matmul_pkg::ram_addr_t host_addr,
    output logic                  host_we,
    output matmul_pkg::ram_word_u host_wdata,
    input  matmul_pkg::ram_word_u host_rdata
);

    logic access;
    logic mem_rd;       // memory read, takes the wait state
    logic rd_wait;
    logic bad_addr;
    logic ro_write;
    logic busy_write;
    logic err;
    logic wr_ok;
    logic start_wr;
    logic done_bit;     // status bit 1

    assign access = psel && penable;
    assign mem_rd = !pwrite && (paddr < `RAM_WORDS);

    //////////////////////////////////////////////////
    // transfer completion and error rule
    //////////////////////////////////////////////////

    assign bad_addr   = (paddr == '1);
    assign ro_write   = pwrite && ((paddr >= `C_BASE && paddr < `RAM_WORDS) ||
                                   paddr == `REG_STATUS);
    assign busy_write = pwrite && busy &&
                        (paddr < `C_BASE || (paddr == `REG_CTRL && pwdata[0]));
    assign err        = bad_addr || ro_write || busy_write;

    assign pready   = access && (!mem_rd || rd_wait);
    assign pslverr  = pready && err;
    assign wr_ok    = pready && pwrite && !err;
    assign start_wr = wr_ok && paddr == `REG_CTRL && pwdata[0];

    // operand writes go straight to memory, low bits only
    assign host_addr = paddr;
    assign host_we   = wr_ok && paddr < `C_BASE;

    always_comb begin
        host_wdata               = '0;
        host_wdata.operand.value = pwdata[`ELEM_W-1:0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_wait  <= 1'b0;
            start    <= 1'b0;
            done_bit <= 1'b0;
            disp_sel <= '0;
        end else begin
            rd_wait <= access && mem_rd && !rd_wait;  // one wait state
            start   <= start_wr;
            if (start_wr) begin
                done_bit <= 1'b0;
            end else if (done) begin
                done_bit <= 1'b1;
            end
            if (wr_ok && paddr == `REG_DISP_SEL) begin
                disp_sel <= pwdata[1:0];
            end
        end
    end

    // read data, unused addresses and ctrl read as zero
    always_comb begin
        prdata = '0;
        if (paddr < `C_BASE) begin
            prdata[`ELEM_W-1:0] = host_rdata.operand.value;
        end else if (paddr < `RAM_WORDS) begin
            prdata[`RESULT_W-1:0] = host_rdata.result.value;
        end else if (paddr == `REG_STATUS) begin
            prdata[1:0] = {done_bit, busy};
        end else if (paddr == `REG_DISP_SEL) begin
            prdata[1:0] = disp_sel;
        end
    end

endmodule

/* source/matrix_ram.sv */
`include "matmul_params.svh"

module matrix_ram (
    input  logic                  clk,
    input  logic                  rst,
    input  matmul_pkg::ram_addr_t host_addr,
    input  logic                  host_we,
    input  matmul_pkg::ram_word_u host_wdata,
    output matmul_pkg::ram_word_u host_rdata,
    input  matmul_pkg::ram_addr_t eng_addr,
    input  logic                  eng_we,
    input  matmul_pkg::ram_word_u eng_wdata,
    output matmul_pkg::ram_word_u eng_rdata
);
    import matmul_pkg::*;

    ram_word_u mem [`RAM_WORDS];    // A, B, then C

    // host writes operands, engine writes results
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RAM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (host_we) begin
                mem[host_addr] <= host_wdata;
            end
            if (eng_we) begin
                mem[eng_addr] <= eng_wdata;
            end
        end
    end

    // one cycle read latency on both ports
    always_ff @(posedge clk) begin
        host_rdata <= (host_addr < `RAM_WORDS) ? mem[host_addr] : '0;  // regs read 0
        eng_rdata  <= mem[eng_addr];
    end

endmodule

/* source/matmul_engine.sv */
`include "matmul_params.svh"

module matmul_engine (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    output logic                  busy,
    output logic                  done,
    output matmul_pkg::ram_addr_t eng_addr,
    output logic                  eng_we,
    output matmul_pkg::ram_word_u eng_wdata,
    input  matmul_pkg::ram_word_u eng_rdata,
    output matmul_pkg::result_t   c11,
    output matmul_pkg::result_t   c12,
    output matmul_pkg::result_t   c21,
    output matmul_pkg::result_t   c22
);
    import matmul_pkg::*;

    // nine steps per element, READ_A1 through UPDATE
    localparam logic [3:0] S_IDLE     = 4'd0;
    localparam logic [3:0] S_READ_A1  = 4'd1;
    localparam logic [3:0] S_LOAD_A1  = 4'd2;   // also reads A2
    localparam logic [3:0] S_LOAD_A2  = 4'd3;   // also reads B1
    localparam logic [3:0] S_LOAD_B1  = 4'd4;   // also reads B2
    localparam logic [3:0] S_LOAD_B2  = 4'd5;
    localparam logic [3:0] S_MULTIPLY = 4'd6;
    localparam logic [3:0] S_ADD      = 4'd7;
    localparam logic [3:0] S_WRITE    = 4'd8;
    localparam logic [3:0] S_UPDATE   = 4'd9;

    logic [3:0] state;
    logic [1:0] iteration;      // result element, row-major
    logic [3:0] rd_step;
    logic [3:0] ld_step;
    ram_addr_t  op_addr [4];
    elem_t      rf [4];         // A1, A2, B1, B2
    prod_t      prod0;
    prod_t      prod1;
    result_t    acc;

    assign busy    = (state != S_IDLE);
    assign rd_step = state - S_READ_A1;
    assign ld_step = state - S_LOAD_A1;

    // operand words per element
    always_comb begin
        case (iteration)
            2'd0:    op_addr = '{4'd0, 4'd1, 4'd4, 4'd6};   // row 1 of A, col 1 of B
            2'd1:    op_addr = '{4'd0, 4'd1, 4'd5, 4'd7};
            2'd2:    op_addr = '{4'd2, 4'd3, 4'd4, 4'd6};
            default: op_addr = '{4'd2, 4'd3, 4'd5, 4'd7};
        endcase
    end

    //////////////////////////////////////////////////
    // memory port
    //////////////////////////////////////////////////

    always_comb begin
        eng_addr  = '0;
        eng_we    = 1'b0;
        eng_wdata = '0;
        if (state >= S_READ_A1 && state <= S_LOAD_B1) begin
            eng_addr = op_addr[rd_step[1:0]];
        end else if (state == S_WRITE) begin
            eng_we                 = 1'b1;
            eng_addr               = ram_addr_t'(`C_BASE) + ram_addr_t'(iteration);
            eng_wdata.result.value = acc;
        end
    end

    //////////////////////////////////////////////////
    // register file and multipliers
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state >= S_LOAD_A1 && state <= S_LOAD_B2) begin
            rf[ld_step[1:0]] <= eng_rdata.operand.value;
        end
        if (state == S_MULTIPLY) begin
            prod0 <= prod_t'(rf[0]) * prod_t'(rf[2]);   // A1 * B1
            prod1 <= prod_t'(rf[1]) * prod_t'(rf[3]);   // A2 * B2
        end
    end

    // sequencer, accumulator and result registers
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            iteration <= '0;
            acc       <= '0;
            done      <= 1'b0;
            c11       <= '0;
            c12       <= '0;
            c21       <= '0;
            c22       <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state <= S_READ_A1;
                    end
                end
                S_UPDATE: begin
                    state     <= (iteration == 2'd3) ? S_IDLE : S_READ_A1;
                    iteration <= iteration + 2'd1;  // wraps back to C11
                    done      <= (iteration == 2'd3);
                end
                default: state <= state + 4'd1;
            endcase

            if (state == S_ADD) begin
                acc <= acc + result_t'(prod0) + result_t'(prod1);
            end else if (state == S_UPDATE) begin
                acc <= '0;
            end

            if (state == S_WRITE) begin
                case (iteration)
                    2'd0:    c11 <= acc;
                    2'd1:    c12 <= acc;
                    2'd2:    c21 <= acc;
                    default: c22 <= acc;
                endcase
            end
        end
    end

endmodule

/* source/result_display.sv */
`include "matmul_params.svh"

module result_display (
    input  logic                clk,
    input  logic                rst,
    input  logic                done,
    input  logic [1:0]          disp_sel,
    input  matmul_pkg::result_t c11,
    input  matmul_pkg::result_t c12,
    input  matmul_pkg::result_t c21,
    input  matmul_pkg::result_t c22,
    output logic [6:0]          seg,
    output logic                dp,
    output logic [3:0]          anode
);
    import matmul_pkg::*;

    localparam int BCD_W      = 8;              // ones and tens
    localparam int CONV_STEPS = 2 * `RESULT_W;  // add and shift per bit
    localparam int IDX_W      = $clog2(`NUM_DIGITS);
    localparam logic [`NUM_DIGITS-1:0] FIRST_DIGIT = 1;

    logic [1:0]                      sel_q;
    logic                            load;
    result_t                         sel_value;
    logic [BCD_W+`RESULT_W-1:0]      shreg;
    logic [$clog2(CONV_STEPS+1)-1:0] conv_cnt;
    logic                            converting;
    logic [BCD_W-1:0]                bcd;       // shown digits
    logic [`SCAN_CNT_W-1:0]          scan_cnt;
    logic [IDX_W-1:0]                digit_idx;
    logic [4*`NUM_DIGITS-1:0]        digits;
    logic [3:0]                      digit;

    assign load = done || (disp_sel != sel_q);

    always_comb begin
        case (disp_sel)
            2'd0:    sel_value = c11;
            2'd1:    sel_value = c12;
            2'd2:    sel_value = c21;
            default: sel_value = c22;
        endcase
    end

    //////////////////////////////////////////////////
    // shift-and-add-3 conversion
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            sel_q      <= '0;
            converting <= 1'b0;
            conv_cnt   <= '0;
            bcd        <= '0;
        end else begin
            sel_q <= disp_sel;
            if (load) begin
                shreg      <= {{BCD_W{1'b0}}, sel_value};
                conv_cnt   <= '0;
                converting <= 1'b1;     // restarts a running conversion
            end else if (converting) begin
                conv_cnt <= conv_cnt + 1'b1;
                if (conv_cnt == CONV_STEPS) begin
                    bcd        <= shreg[BCD_W+`RESULT_W-1:`RESULT_W];
                    converting <= 1'b0;
                end else if (!conv_cnt[0]) begin
                    for (int d = 0; d < BCD_W / 4; d++) begin
                        if (shreg[`RESULT_W+4*d +: 4] > 4'd4) begin
                            shreg[`RESULT_W+4*d +: 4] <= shreg[`RESULT_W+4*d +: 4] + 4'd3;
                        end
                    end
                end else begin
                    shreg <= shreg << 1;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // digit scan and segment decode
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            scan_cnt  <= '0;
            digit_idx <= '0;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
            if (&scan_cnt) begin
                digit_idx <= digit_idx + 1'b1;  // next anode to the left
            end
        end
    end

    assign anode  = ~(FIRST_DIGIT << digit_idx);
    assign digits = {{(4*`NUM_DIGITS-BCD_W){1'b0}}, bcd};   // upper digits show 0
    assign digit  = digits[4*digit_idx +: 4];
    assign dp     = 1'b1;

    // a..g, active low
    always_comb begin
        case (digit)
            4'd0:    seg = 7'b0000001;
            4'd1:    seg = 7'b1001111;
            4'd2:    seg = 7'b0010010;
            4'd3:    seg = 7'b0000110;
            4'd4:    seg = 7'b1001100;
            4'd5:    seg = 7'b0100100;
            4'd6:    seg = 7'b0100000;
            4'd7:    seg = 7'b0001111;
            4'd8:    seg = 7'b0000000;
            4'd9:    seg = 7'b0001100;
            default: seg = 7'b1111111;  // blank
        endcase
    end

endmodule

/* source/matrix_accumulator.sv */
`include "matmul_params.svh"

module matrix_accumulator (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  matmul_pkg::ram_addr_t paddr,
    input  logic [`WORD_W-1:0]    pwdata,
    output logic [`WORD_W-1:0]    prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic [6:0]            seg,
    output logic                  dp,
    output logic [3:0]            anode
);
    import matmul_pkg::*;

    // port to engine and display
    logic       start;
    logic       busy;
    logic       done;
    logic [1:0] disp_sel;

    // memory ports
    ram_addr_t  host_addr;
    logic       host_we;
    ram_word_u  host_wdata;
    ram_word_u  host_rdata;
    ram_addr_t  eng_addr;
    logic       eng_we;
    ram_word_u  eng_wdata;
    ram_word_u  eng_rdata;

    // results, straight to the display
    result_t    c11;
    result_t    c12;
    result_t    c21;
    result_t    c22;

    apb_matrix_port port_i (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .busy       (busy),
        .done       (done),
        .start      (start),
        .disp_sel   (disp_sel),
        .host_addr  (host_addr),
        .host_we    (host_we),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata)
    );

    matrix_ram ram_i (
        .clk        (clk),
        .rst        (rst),
        .host_addr  (host_addr),
        .host_we    (host_we),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata),
        .eng_addr   (eng_addr),
        .eng_we     (eng_we),
        .eng_wdata  (eng_wdata),
        .eng_rdata  (eng_rdata)
    );

    matmul_engine engine_i (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .busy      (busy),
        .done      (done),
        .eng_addr  (eng_addr),
        .eng_we    (eng_we),
        .eng_wdata (eng_wdata),
        .eng_rdata (eng_rdata),
        .c11       (c11),
        .c12       (c12),
        .c21       (c21),
        .c22       (c22)
    );

    result_display display_i (
        .clk      (clk),
        .rst      (rst),
        .done     (done),
        .disp_sel (disp_sel),
        .c11      (c11),
        .c12      (c12),
        .c21      (c21),
        .c22      (c22),
        .seg      (seg),
        .dp       (dp),
        .anode    (anode)
    );

endmodule

/* verification/matrix_accumulator_tb.sv */
`include "matmul_params.svh"

module matrix_accumulator_tb;
    import matmul_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_SETS   = 21;     // twenty random, then all 3
    localparam int NUM_TESTS  = 28;     // reset, readback, sets, errors, four selects

    logic               clk;
    logic               rst;
    logic               psel;
    logic               penable;
    logic               pwrite;
    ram_addr_t          paddr;
    logic [`WORD_W-1:0] pwdata;
    logic [`WORD_W-1:0] prdata;
    logic               pready;
    logic               pslverr;
    logic [6:0]         seg;
    logic               dp;
    logic [3:0]         anode;

    integer seed        = 99925;
    int     error_count = 0;
    int     check_count = 0;
    int     test_count  = 0;
    int     test_errors;            // error count when the test began
    string  test_name;
    elem_t  op_model [8];           // host copy of words 0 to 7

    // pending checks
    string              name_q [$];
    logic [`WORD_W-1:0] exp_q [$];
    logic [`WORD_W-1:0] act_q [$];
    time                time_q [$];

    matrix_accumulator matrix_accumulator_i (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .seg     (seg),
        .dp      (dp),
        .anode   (anode)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(NUM_TESTS * 400 * CLK_PERIOD);
        $display("timeout, the tests did not finish in time");
        $display("=== FAIL ===");
        $finish;
    end

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    // Cij = sum over k of Aik * Bkj with idx in row-major order
    function automatic result_t matmul_ref(input int idx);
        int row;
        int col;
        int sum;
        row = idx / 2;
        col = idx % 2;
        sum = 0;
        for (int k = 0; k < 2; k++) begin
            sum += int'(op_model[`A_BASE + 2 * row + k]) * int'(op_model[`B_BASE + 2 * k + col]);
        end
        return result_t'(sum);
    endfunction

    function automatic logic [6:0] seg_pattern(input int digit);
        case (digit)
            0:       return 7'b0000001;
            1:       return 7'b1001111;
            2:       return 7'b0010010;
            3:       return 7'b0000110;
            4:       return 7'b1001100;
            5:       return 7'b0100100;
            6:       return 7'b0100000;
            7:       return 7'b0001111;
            8:       return 7'b0000000;
            9:       return 7'b0001100;
            default: return 7'b1111111;
        endcase
    endfunction

    task automatic expect_value(input string name, input logic [`WORD_W-1:0] exp,
                                input logic [`WORD_W-1:0] act);
        name_q.push_back(name);
        exp_q.push_back(exp);
        act_q.push_back(act);
        time_q.push_back($time);
    endtask

    // compares on the falling edge away from the drive edge
    always @(negedge clk) begin
        while (exp_q.size() > 0) begin
            check_count++;
            assert (act_q[0] === exp_q[0]) else begin
                $display("error at %0t: %s expected %0h, got %0h",
                         time_q[0], name_q[0], exp_q[0], act_q[0]);
                error_count++;
            end
            name_q.delete(0);
            exp_q.delete(0);
            act_q.delete(0);
            time_q.delete(0);
        end
    end

    //////////////////////////////////////////////////
    // bus tasks
    //////////////////////////////////////////////////

    task automatic transfer(input logic write, input ram_addr_t addr,
                            input logic [`WORD_W-1:0] wdata,
                            output logic [`WORD_W-1:0] rdata, output logic err);
        int waits;
        int exp_waits;
        waits     = 0;
        exp_waits = (!write && addr < `RAM_WORDS) ? 1 : 0;  // memory reads wait once
        @(posedge clk);
        psel    <= 1'b1;    // setup phase
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready && waits < 8) begin
            waits++;
            @(negedge clk);
        end
        assert (pready) else begin
            $display("no pready from the DUT for address %0d", addr);
            error_count++;
        end
        expect_value($sformatf("pready wait states (address %0d)", addr), 8'(exp_waits),
                     8'(waits));
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic write_reg(input ram_addr_t addr, input logic [`WORD_W-1:0] data,
                             input logic exp_err);
        logic [`WORD_W-1:0] unused;
        logic               err;
        transfer(1'b1, addr, data, unused, err);
        expect_value($sformatf("pslverr (write %0d)", addr), 8'(exp_err), 8'(err));
    endtask

    task automatic read_reg(input ram_addr_t addr, input logic exp_err,
                            output logic [`WORD_W-1:0] data);
        logic err;
        transfer(1'b0, addr, '0, data, err);
        expect_value($sformatf("pslverr (read %0d)", addr), 8'(exp_err), 8'(err));
    endtask

    task automatic load_operands(input logic all_three);
        logic [`WORD_W-1:0] wbyte;
        for (int i = 0; i < 8; i++) begin
            wbyte = all_three ? 8'hff : 8'($random(seed));
            write_reg(ram_addr_t'(i), wbyte, 1'b0);
            op_model[i] = wbyte[`ELEM_W-1:0];   // only the low bits are kept
        end
    endtask

    task automatic wait_done();
        logic [`WORD_W-1:0] status;
        int                 polls;
        polls  = 0;
        status = '0;
        while (!status[1] && polls < 40) begin
            read_reg(`REG_STATUS, 1'b0, status);
            polls++;
        end
        assert (status[1]) else begin
            $display("done bit not set after %0d status polls", polls);
            error_count++;
        end
        expect_value("prdata (status after done)", 8'h02, status);
    endtask

    task automatic check_results();
        logic [`WORD_W-1:0] data;
        for (int i = 0; i < 4; i++) begin
            read_reg(ram_addr_t'(`C_BASE + i), 1'b0, data);
            expect_value($sformatf("prdata (word %0d)", `C_BASE + i), 8'(matmul_ref(i)), data);
        end
    endtask

    task automatic wait_anode(input int pos);
        logic [3:0] target;
        int         cycles;
        target = ~(4'b0001 << pos);
        cycles = 0;
        @(negedge clk);
        while (anode != target && cycles < 4 * (1 << `SCAN_CNT_W)) begin
            cycles++;
            @(negedge clk);
        end
        assert (anode == target) else begin
            $display("anode never reached digit %0d", pos);
            error_count++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = error_count;
    endtask

    task automatic finish_test();
        while (exp_q.size() > 0) begin
            @(posedge clk);
        end
        test_count++;
        if (error_count == test_errors) begin
            $display("test %0d %s: ok", test_count, test_name);
        end else begin
            $display("test %0d %s: failed with %0d errors", test_count, test_name,
                     error_count - test_errors);
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    initial begin
        logic [`WORD_W-1:0] data;
        logic [`WORD_W-1:0] word9;
        int                 result;
        int                 digit;
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        foreach (op_model[i]) begin
            op_model[i] = '0;
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        begin_test("reset");
        @(negedge clk);
        expect_value("pready", 8'd0, 8'(pready));
        expect_value("pslverr", 8'd0, 8'(pslverr));
        expect_value("anode", 8'(4'b1110), 8'(anode));
        expect_value("seg", 8'(seg_pattern(0)), 8'(seg));
        expect_value("dp", 8'd1, 8'(dp));
        read_reg(`REG_STATUS, 1'b0, data);
        expect_value("prdata (status)", 8'h00, data);
        check_results();        // all zero operands
        finish_test();

        begin_test("operand readback");
        load_operands(1'b0);
        for (int i = 0; i < 8; i++) begin
            read_reg(ram_addr_t'(i), 1'b0, data);
            expect_value($sformatf("prdata (word %0d)", i), 8'(op_model[i]), data);
        end
        finish_test();

        for (int s = 0; s < NUM_SETS; s++) begin
            begin_test($sformatf("product set %0d", s));
            load_operands(s == NUM_SETS - 1);
            write_reg(`REG_CTRL, 8'h01, 1'b0);
            wait_done();
            check_results();
            finish_test();
        end

        begin_test("error rule");
        read_reg(`C_BASE + 1, 1'b0, word9);
        write_reg(`C_BASE + 1, 8'h1f, 1'b1);
        read_reg(`C_BASE + 1, 1'b0, data);
        expect_value("prdata (word 9)", word9, data);
        write_reg(`REG_STATUS, 8'h03, 1'b1);
        load_operands(1'b0);
        write_reg(`REG_CTRL, 8'h01, 1'b0);
        read_reg(`REG_STATUS, 1'b0, data);
        expect_value("prdata (status while busy)", 8'h01, data);
        write_reg(`A_BASE, {6'b0, ~op_model[0]}, 1'b1);     // refused while busy
        write_reg(`REG_CTRL, 8'h01, 1'b1);
        write_reg(4'hf, 8'h00, 1'b1);
        read_reg(4'hf, 1'b1, data);
        expect_value("prdata (address 15)", 8'h00, data);
        wait_done();
        check_results();
        read_reg(`A_BASE, 1'b0, data);
        expect_value("prdata (word 0)", 8'(op_model[0]), data);
        finish_test();

        for (int sel = 0; sel < 4; sel++) begin
            begin_test($sformatf("display select %0d", sel));
            write_reg(`REG_DISP_SEL, 8'(sel), 1'b0);
            read_reg(`REG_DISP_SEL, 1'b0, data);
            expect_value("prdata (display select)", 8'(sel), data);
            repeat (2 * `RESULT_W + 3) @(posedge clk);      // conversion plus margin
            result = matmul_ref(sel);
            for (int pos = 0; pos < `NUM_DIGITS; pos++) begin
                wait_anode(pos);
                digit = (pos == 0) ? result % 10 : (pos == 1) ? result / 10 : 0;
                expect_value($sformatf("seg (digit %0d)", pos), 8'(seg_pattern(digit)),
                             8'(seg));
            end
            finish_test();
        end

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* matrix_accumulator.f */
+incdir+source
source/matmul_pkg.sv
source/apb_matrix_port.sv
source/matrix_ram.sv
source/matmul_engine.sv
source/result_display.sv
source/matrix_accumulator.sv
verification/matrix_accumulator_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the matrix accumulator testbench with Verilator
set -e

cd "$(dirname "$0")"

TOP=matrix_accumulator_tb
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f matrix_accumulator.f \
    --top-module "$TOP" \
    -o "$TOP"

./obj_dir/"$TOP" | tee "$LOG"

if grep -q "^=== PASS ===$" "$LOG"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
